// ==== run.sh ====
#!/bin/sh
# builds the FPU testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sim.f --top-module fpuTb -o simv > build.log 2>&1 \
   && ./obj_dir/simv > sim.log 2>&1
grep -q "TESTBENCH FAILED" sim.log 2>/dev/null && { echo "simulation failed"; exit 1; }
[ -f sim.log ] && grep -q "TESTBENCH PASSED" sim.log || { echo "build or run failed"; exit 1; }
echo "simulation passed"

// ==== sim.f ====
source/fpuPkg.sv
source/fpuRegFile.sv
source/fpuDecode.sv
source/fpuHazard.sv
source/fpuExecute.sv
source/fpu.sv
testbench/tbClock.sv
testbench/fpu_props.sv
testbench/fpuTb.sv

// ==== source/fpu.sv ====
/*
  single-precision FPU top, stages D E M W, results out 2 edges after acceptance
  a load-use stall holds E for one cycle, its result then comes one edge later
  intSrcE must stay valid for every cycle the fmv.w.x sits in E
  readDataW is sampled in the cycle the load is in W
*/
`default_nettype none

module fpu (
   input  logic                        clk,
   input  logic                        arstN,
   input  logic [fpuPkg::flen-1:0]     instrD,
   input  logic [fpuPkg::xlen-1:0]     intSrcE,
   input  logic [fpuPkg::flen-1:0]     readDataW,
   output logic [fpuPkg::xlen-1:0]     fIntResM,     // to integer register file
   output logic                        fWriteIntM,
   output logic [fpuPkg::flagW-1:0]    setFflagsM,
   output logic [fpuPkg::flen-1:0]     fWriteDataM,  // fsw data
   output logic                        fStoreM,
   output logic                        fStallD
);

   logic [fpuPkg::regAdrW-1:0] adr1D, adr2D, adr1E, adr2E, rdM, rdW;
   logic                       xEnE, yEnE, regWriteM, regWriteW, loadM;
   fpuPkg::fpOpE               opE, opM, opW;
   fpuPkg::fwdSelE             fwdXE, fwdYE;
   logic [fpuPkg::flen-1:0]    rd1D, rd2D, rd1E, rd2E, xE, yE;
   logic [fpuPkg::flen-1:0]    fpResE, fpResM, fpResW, resultW;
   logic [fpuPkg::xlen-1:0]    intResE;
   logic                       nvE, nvM;

   function automatic logic [fpuPkg::flen-1:0] fwdMux(input fpuPkg::fwdSelE sel,
         input logic [fpuPkg::flen-1:0] regVal, wVal, mVal);
      case (sel)
         fpuPkg::fwdW: return wVal;
         fpuPkg::fwdM: return mVal;
         default:      return regVal;
      endcase
   endfunction

   fpuDecode u_decode (.clk, .arstN, .instrD, .fStallD, .adr1D, .adr2D, .adr1E, .adr2E,
      .xEnE, .yEnE, .opE, .opM, .opW, .regWriteM, .regWriteW, .loadM, .rdM, .rdW);

   fpuRegFile u_regFile (.clk, .arstN, .adr1(adr1D), .adr2(adr2D), .rd1(rd1D), .rd2(rd2D),
      .we(regWriteW), .wAdr(rdW), .wData(resultW));

   fpuHazard u_hazard (.adr1E, .adr2E, .rdM, .rdW, .xEnE, .yEnE, .regWriteM, .regWriteW,
      .loadM, .fwdXE, .fwdYE, .fStallD);

   ////////////////////
   // D to E
   ////////////////////
   always_ff @(posedge clk) begin
      if (fStallD) begin                   // keep the forwarded values, the producer leaves M/W
         rd1E <= xE;
         rd2E <= yE;
      end else begin
         rd1E <= rd1D;
         rd2E <= rd2D;
      end
   end

   // forwarding muxes
   assign xE = fwdMux(fwdXE, rd1E, resultW, fpResM);
   assign yE = fwdMux(fwdYE, rd2E, resultW, fpResM);

   fpuExecute u_execute (.opE, .xE, .yE, .intSrcE, .fpResE, .intResE, .nvE);

   ////////////////////
   // E to M, M to W
   ////////////////////
   always_ff @(posedge clk) begin
      fpResM      <= fpResE;
      fIntResM    <= intResE;
      fWriteDataM <= yE;                   // store data is rs2
      fpResW      <= fpResM;
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) nvM <= 1'b0;
      else        nvM <= nvE & ~fStallD;   // nothing flags on a bubble
   end

   assign fWriteIntM = opM inside {fpuPkg::opEq, fpuPkg::opLt, fpuPkg::opLe, fpuPkg::opClass,
                                   fpuPkg::opMvX};
   assign fStoreM    = (opM == fpuPkg::opStore);

   always_comb begin
      setFflagsM = '0;
      setFflagsM[fpuPkg::nvBit] = nvM;     // only NV can be raised here
   end

   // writeback select, load data or FP result
   assign resultW = (opW == fpuPkg::opLoad) ? readDataW : fpResW;

endmodule

`default_nettype wire

// ==== source/fpuDecode.sv ====
/*
  decodes OP-FP, flw and fsw into an fpOpE, anything else is a bubble
  carries op and destination through E, M and W
  under fStallD the E stage holds and a bubble enters M
  instrD must be held by the environment while fStallD is high
*/
`default_nettype none

module fpuDecode (
   input  logic                        clk,
   input  logic                        arstN,
   input  logic [fpuPkg::flen-1:0]     instrD,
   input  logic                        fStallD,
   output logic [fpuPkg::regAdrW-1:0]  adr1D,    // register file read addresses
   output logic [fpuPkg::regAdrW-1:0]  adr2D,
   output logic [fpuPkg::regAdrW-1:0]  adr1E,
   output logic [fpuPkg::regAdrW-1:0]  adr2E,
   output logic                        xEnE,     // op in E reads rs1
   output logic                        yEnE,     // op in E reads rs2
   output fpuPkg::fpOpE                opE,
   output fpuPkg::fpOpE                opM,
   output fpuPkg::fpOpE                opW,
   output logic                        regWriteM,
   output logic                        regWriteW,
   output logic                        loadM,
   output logic [fpuPkg::regAdrW-1:0]  rdM,
   output logic [fpuPkg::regAdrW-1:0]  rdW
);

   logic [6:0]                  opcode, funct7;
   logic [2:0]                  funct3;
   logic [fpuPkg::regAdrW-1:0]  rdD, rdE;
   logic                        xEnD, yEnD;
   fpuPkg::fpOpE                opD;

   // ops that end in an FP register write
   function automatic logic writesFp(input fpuPkg::fpOpE op);
      return op inside {fpuPkg::opSgnj, fpuPkg::opSgnjn, fpuPkg::opSgnjx, fpuPkg::opMin,
                        fpuPkg::opMax, fpuPkg::opMvW, fpuPkg::opLoad};
   endfunction

   assign opcode = instrD[6:0];
   assign funct3 = instrD[14:12];
   assign funct7 = instrD[31:25];
   assign rdD    = instrD[11:7];
   assign adr1D  = instrD[19:15];
   assign adr2D  = instrD[24:20];          // also the rs2 sub-opcode for moves and fclass

   ////////////////////
   // decode
   ////////////////////
   always_comb begin
      opD = fpuPkg::opNone;
      case (opcode)
         fpuPkg::opLoadFp:  if (funct3 == 3'b010) opD = fpuPkg::opLoad;
         fpuPkg::opStoreFp: if (funct3 == 3'b010) opD = fpuPkg::opStore;
         fpuPkg::opOpFp: begin
            case (funct7)
               fpuPkg::f7Sgnj: begin
                  if (funct3 == 3'b000) opD = fpuPkg::opSgnj;
                  else if (funct3 == 3'b001) opD = fpuPkg::opSgnjn;
                  else if (funct3 == 3'b010) opD = fpuPkg::opSgnjx;
               end
               fpuPkg::f7MinMax: begin
                  if (funct3 == 3'b000) opD = fpuPkg::opMin;
                  else if (funct3 == 3'b001) opD = fpuPkg::opMax;
               end
               fpuPkg::f7Cmp: begin
                  if (funct3 == 3'b010) opD = fpuPkg::opEq;
                  else if (funct3 == 3'b001) opD = fpuPkg::opLt;
                  else if (funct3 == 3'b000) opD = fpuPkg::opLe;
               end
               fpuPkg::f7MvXClass: begin
                  if (adr2D == '0 && funct3 == 3'b000) opD = fpuPkg::opMvX;
                  else if (adr2D == '0 && funct3 == 3'b001) opD = fpuPkg::opClass;
               end
               fpuPkg::f7MvW: if (adr2D == '0 && funct3 == 3'b000) opD = fpuPkg::opMvW;
               default: opD = fpuPkg::opNone;
            endcase
         end
         default: opD = fpuPkg::opNone;   // not ours, becomes a bubble
      endcase
   end

   // source usage, only enabled sources take part in forwarding and stalls
   assign xEnD = opD inside {[fpuPkg::opSgnj:fpuPkg::opMvX]};
   assign yEnD = opD inside {[fpuPkg::opSgnj:fpuPkg::opLe], fpuPkg::opStore};

   ////////////////////
   // control pipe
   ////////////////////
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         opE <= fpuPkg::opNone;
         opM <= fpuPkg::opNone;
         opW <= fpuPkg::opNone;
         {adr1E, adr2E, rdE, rdM, rdW} <= '0;
         {xEnE, yEnE} <= '0;
      end else begin
         if (!fStallD) begin               // E holds while waiting for the load
            opE   <= opD;
            adr1E <= adr1D;
            adr2E <= adr2D;
            rdE   <= rdD;
            xEnE  <= xEnD;
            yEnE  <= yEnD;
         end
         opM <= fStallD ? fpuPkg::opNone : opE;   // bubble into M
         rdM <= rdE;
         opW <= opM;
         rdW <= rdM;
      end
   end

   assign regWriteM = writesFp(opM);
   assign regWriteW = writesFp(opW);
   assign loadM     = (opM == fpuPkg::opLoad);

endmodule

`default_nettype wire

// ==== source/fpuExecute.sv ====
/*
  E-stage datapath: sign injection, min/max, compares, fclass and moves
  no rounding, every result here is exact
  min/max order -0 below +0, feq treats them as equal
*/
`default_nettype none

module fpuExecute (
   input  fpuPkg::fpOpE                opE,
   input  logic [fpuPkg::flen-1:0]     xE,
   input  logic [fpuPkg::flen-1:0]     yE,
   input  logic [fpuPkg::xlen-1:0]     intSrcE,   // fmv.w.x source
   output logic [fpuPkg::flen-1:0]     fpResE,
   output logic [fpuPkg::xlen-1:0]     intResE,
   output logic                        nvE         // invalid flag
);

   typedef struct packed {
      logic sign;
      logic zero;
      logic sub;
      logic norm;
      logic inf;
      logic sNaN;
      logic qNaN;
   } opInfoT;

   opInfoT                      xI, yI;
   logic [fpuPkg::flen-2:0]     xMag, yMag;       // exponent and fraction together
   logic                        anyNaN, anySNaN, bothZero;
   logic                        ltOrd, ltCmp, eqCmp;
   logic [fpuPkg::flen-1:0]     minMaxRes;
   logic [fpuPkg::xlen-1:0]     classRes;

   // unpack sign, exponent and fraction and classify
   function automatic opInfoT unpack(input logic [fpuPkg::flen-1:0] v);
      logic [fpuPkg::ne-1:0] expo;
      logic [fpuPkg::nf-1:0] frac;
      logic                  expMax, expZero, fracZero;
      opInfoT                info;
      expo     = v[fpuPkg::flen-2 -: fpuPkg::ne];
      frac     = v[fpuPkg::nf-1:0];
      expMax   = &expo;
      expZero  = ~|expo;
      fracZero = ~|frac;
      info.sign = v[fpuPkg::flen-1];
      info.zero = expZero & fracZero;
      info.sub  = expZero & ~fracZero;
      info.norm = ~expZero & ~expMax;
      info.inf  = expMax & fracZero;
      info.sNaN = expMax & ~fracZero & ~frac[fpuPkg::nf-1];   // quiet bit clear
      info.qNaN = expMax & frac[fpuPkg::nf-1];
      return info;
   endfunction

   assign xI   = unpack(xE);
   assign yI   = unpack(yE);
   assign xMag = xE[fpuPkg::flen-2:0];
   assign yMag = yE[fpuPkg::flen-2:0];

   assign anyNaN   = xI.sNaN | xI.qNaN | yI.sNaN | yI.qNaN;
   assign anySNaN  = xI.sNaN | yI.sNaN;
   assign bothZero = xI.zero & yI.zero;

   ////////////////////
   // ordering
   ////////////////////
   // sign-magnitude order on raw bits, -0 < +0, NaNs handled outside
   assign ltOrd = (xI.sign != yI.sign) ? xI.sign
                : (xI.sign ? (yMag < xMag) : (xMag < yMag));
   assign ltCmp = ltOrd & ~bothZero;             // compare sees +-0 as equal
   assign eqCmp = (xE == yE) | bothZero;

   always_comb begin
      if ((xI.sNaN | xI.qNaN) && (yI.sNaN | yI.qNaN)) begin
         minMaxRes = fpuPkg::canonNaN;
      end else if (xI.sNaN | xI.qNaN) begin
         minMaxRes = yE;                          // the non-NaN operand wins
      end else if (yI.sNaN | yI.qNaN) begin
         minMaxRes = xE;
      end else begin
         minMaxRes = ((opE == fpuPkg::opMin) == ltOrd) ? xE : yE;
      end
   end

   // fclass one-hot
   always_comb begin
      classRes = '0;
      classRes[fpuPkg::classNegInf]  = xI.sign & xI.inf;
      classRes[fpuPkg::classNegNorm] = xI.sign & xI.norm;
      classRes[fpuPkg::classNegSub]  = xI.sign & xI.sub;
      classRes[fpuPkg::classNegZero] = xI.sign & xI.zero;
      classRes[fpuPkg::classPosZero] = ~xI.sign & xI.zero;
      classRes[fpuPkg::classPosSub]  = ~xI.sign & xI.sub;
      classRes[fpuPkg::classPosNorm] = ~xI.sign & xI.norm;
      classRes[fpuPkg::classPosInf]  = ~xI.sign & xI.inf;
      classRes[fpuPkg::classSNaN]    = xI.sNaN;    // NaN sign ignored
      classRes[fpuPkg::classQNaN]    = xI.qNaN;
   end

   ////////////////////
   // result select
   ////////////////////
   always_comb begin
      fpResE = '0;
      case (opE)
         fpuPkg::opSgnj:  fpResE = {yI.sign, xMag};
         fpuPkg::opSgnjn: fpResE = {~yI.sign, xMag};
         fpuPkg::opSgnjx: fpResE = {xI.sign ^ yI.sign, xMag};
         fpuPkg::opMin, fpuPkg::opMax: fpResE = minMaxRes;
         fpuPkg::opMvW:   fpResE = intSrcE;      // bit pattern unchanged
         default:         fpResE = '0;
      endcase
   end

   always_comb begin
      intResE = '0;
      case (opE)
         fpuPkg::opEq:    intResE = fpuPkg::xlen'(~anyNaN & eqCmp);
         fpuPkg::opLt:    intResE = fpuPkg::xlen'(~anyNaN & ltCmp);
         fpuPkg::opLe:    intResE = fpuPkg::xlen'(~anyNaN & (ltCmp | eqCmp));
         fpuPkg::opClass: intResE = classRes;
         fpuPkg::opMvX:   intResE = xE;
         default:         intResE = '0;
      endcase
   end

   // signaling compares trap on any NaN, quiet ones only on sNaN
   assign nvE = (opE inside {fpuPkg::opLt, fpuPkg::opLe}) ? anyNaN
              : (opE inside {fpuPkg::opEq, fpuPkg::opMin, fpuPkg::opMax}) ? anySNaN
              : 1'b0;

endmodule

`default_nettype wire

// ==== source/fpuHazard.sv ====
/*
  forwarding selects for the two E-stage sources and load-use stall
  M takes precedence over W
  a load in M cannot forward, its data only exists in W
*/
`default_nettype none

module fpuHazard (
   input  logic [fpuPkg::regAdrW-1:0]  adr1E,
   input  logic [fpuPkg::regAdrW-1:0]  adr2E,
   input  logic [fpuPkg::regAdrW-1:0]  rdM,
   input  logic [fpuPkg::regAdrW-1:0]  rdW,
   input  logic                        xEnE,
   input  logic                        yEnE,
   input  logic                        regWriteM,
   input  logic                        regWriteW,
   input  logic                        loadM,
   output fpuPkg::fwdSelE              fwdXE,
   output fpuPkg::fwdSelE              fwdYE,
   output logic                        fStallD
);

   logic xHitM, yHitM, xHitW, yHitW;

   function automatic fpuPkg::fwdSelE pickFwd(input logic hitM, input logic hitW);
      if (hitM) return fpuPkg::fwdM;       // youngest producer wins
      if (hitW) return fpuPkg::fwdW;
      return fpuPkg::fwdNone;
   endfunction

   // address matches, f0 included
   assign xHitM = xEnE & regWriteM & (adr1E == rdM);
   assign yHitM = yEnE & regWriteM & (adr2E == rdM);
   assign xHitW = xEnE & regWriteW & (adr1E == rdW);
   assign yHitW = yEnE & regWriteW & (adr2E == rdW);

   assign fwdXE = pickFwd(xHitM, xHitW);
   assign fwdYE = pickFwd(yHitM, yHitW);

   // load in M feeding E, hold E one cycle and pick the value up from W
   assign fStallD = loadM & (xHitM | yHitM);

endmodule

`default_nettype wire

// ==== source/fpuPkg.sv ====
/*
  shared widths, encodings and enums for the single-precision FPU
  single format only, no NaN boxing, flen equals xlen
  class positions follow the RISC-V fclass bit order
*/
`default_nettype none

package fpuPkg;

   ////////////////////
   // widths
   ////////////////////
   localparam int flen    = 32;         // FP word
   localparam int xlen    = 32;         // integer word
   localparam int ne      = 8;          // exponent bits
   localparam int nf      = 23;         // fraction bits, hidden bit not stored
   localparam int regAdrW = 5;
   localparam int flagW   = 5;          // NV DZ OF UF NX
   localparam int nvBit   = 4;          // invalid flag position

   // major opcodes
   localparam logic [6:0] opOpFp    = 7'b1010011;
   localparam logic [6:0] opLoadFp  = 7'b0000111;   // flw
   localparam logic [6:0] opStoreFp = 7'b0100111;   // fsw

   // funct7 groups, fmt field 00 is single
   localparam logic [6:0] f7Sgnj     = 7'b0010000;
   localparam logic [6:0] f7MinMax   = 7'b0010100;
   localparam logic [6:0] f7Cmp      = 7'b1010000;
   localparam logic [6:0] f7MvXClass = 7'b1110000;  // fmv.x.w and fclass, rs2 must be 0
   localparam logic [6:0] f7MvW      = 7'b1111000;  // fmv.w.x

   // canonical quiet NaN
   localparam logic [flen-1:0] canonNaN = 32'h7fc0_0000;

   ////////////////////
   // enums
   ////////////////////
   typedef enum logic [3:0] {
      opNone,                                // bubble or undecoded
      opSgnj, opSgnjn, opSgnjx,
      opMin, opMax,
      opEq, opLt, opLe,
      opClass, opMvX, opMvW,
      opLoad, opStore
   } fpOpE;

   typedef enum logic [1:0] {
      fwdNone = 2'd0,                        // register file value
      fwdW    = 2'd1,                        // writeback result
      fwdM    = 2'd2                         // memory stage result
   } fwdSelE;

   // bit positions of the one-hot fclass result
   typedef enum int unsigned {
      classNegInf, classNegNorm, classNegSub, classNegZero,
      classPosZero, classPosSub, classPosNorm, classPosInf,
      classSNaN, classQNaN
   } fpClassE;

endpackage

`default_nettype wire

// ==== source/fpuRegFile.sv ====
/*
  32 x flen FP register file, two read ports and one write port
  write-through: reading the address written this cycle returns wData
  all registers cleared by reset, f0 is an ordinary register
*/
`default_nettype none

module fpuRegFile (
   input  logic                        clk,
   input  logic                        arstN,
   input  logic [fpuPkg::regAdrW-1:0]  adr1,    // rs1
   input  logic [fpuPkg::regAdrW-1:0]  adr2,    // rs2
   output logic [fpuPkg::flen-1:0]     rd1,
   output logic [fpuPkg::flen-1:0]     rd2,
   input  logic                        we,      // writeback strobe
   input  logic [fpuPkg::regAdrW-1:0]  wAdr,
   input  logic [fpuPkg::flen-1:0]     wData
);

   logic [fpuPkg::flen-1:0] regs [2**fpuPkg::regAdrW];

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         regs <= '{default: '0};           // every register reads zero after reset
      end else if (we) begin
         regs[wAdr] <= wData;
      end
   end

   // bypass the write so decode sees the W result in the same cycle
   assign rd1 = (we && (wAdr == adr1)) ? wData : regs[adr1];
   assign rd2 = (we && (wAdr == adr2)) ? wData : regs[adr2];

endmodule

`default_nettype wire

// ==== testbench/fpuTb.sv ====
/*
  table-driven FPU testbench, one instruction per cycle unless stalled
  expected values come from a small model of the RISC-V single rules
  inputs change on the falling edge, outputs are checked there too
*/
`default_nettype none

module fpuTb;
   timeunit 1ns;
   timeprecision 100ps;

   typedef struct {
      logic [31:0]   instr;
      fpuPkg::fpOpE  op;
      int            rs1, rs2;
      logic [31:0]   intSrc, readData, expInt, expStore;
      logic [4:0]    expFlags;
   } entryT;

   logic clk, arstN, fWriteIntM, fStoreM, fStallD;
   logic [31:0] instrD, intSrcE, readDataW, fIntResM, fWriteDataM;
   logic [fpuPkg::flagW-1:0] setFflagsM;
   entryT       tbl[$];
   logic [31:0] model[32];               // shadow FP registers
   logic [31:0] spec[10] = '{32'h0000_0000, 32'h8000_0000, 32'h7f80_0000, 32'hff80_0000,
      32'h7fc0_0000, 32'h7f80_0001, 32'h3f80_0000, 32'hc000_0000, 32'h0000_0001, 32'h807f_ffff};
   int dIdx, eIdx, mIdx, wIdx, nextIdx, cyc, t;
   logic stalled;

   tbClock u_clock (.clk, .arstN);
   fpu i_dut (.clk, .arstN, .instrD, .intSrcE, .readDataW, .fIntResM, .fWriteIntM,
      .setFflagsM, .fWriteDataM, .fStoreM, .fStallD);

   task automatic stopRun(input string why);
      $display("%s", why);
      $display("TESTBENCH FAILED");
      $fatal(1);
   endtask

   task automatic checkInt(input string name, input logic [fpuPkg::xlen-1:0] got, exp);
      if (got !== exp) stopRun($sformatf("Fail %s got %h expected %h", name, got, exp));
   endtask
   task automatic checkFlags(input string name, input logic [fpuPkg::flagW-1:0] got, exp);
      if (got !== exp) stopRun($sformatf("Fail %s got %h expected %h", name, got, exp));
   endtask
   task automatic checkData(input string name, input logic [fpuPkg::flen-1:0] got, exp);
      if (got !== exp) stopRun($sformatf("Fail %s got %h expected %h", name, got, exp));
   endtask
   task automatic checkBit(input string name, input logic got, exp);
      if (got !== exp) stopRun($sformatf("Fail %s got %h expected %h", name, got, exp));
   endtask

   ////////////////////
   // model
   ////////////////////
   function automatic logic isNaN(input logic [31:0] v);
      return (&v[30:23]) && (|v[22:0]);
   endfunction
   function automatic logic isSNaN(input logic [31:0] v);
      return isNaN(v) && !v[22];
   endfunction
   // maps floats onto unsigned integers in the same order, -0 below +0
   function automatic logic [31:0] orderKey(input logic [31:0] v);
      return v[31] ? ~v : {1'b1, v[30:0]};
   endfunction
   function automatic int classIdx(input logic [31:0] v);
      if (&v[30:23]) return (v[22:0] == 0) ? (v[31] ? 0 : 7) : (v[22] ? 9 : 8);
      if (v[30:23] == 0) return (v[22:0] == 0) ? (v[31] ? 3 : 4) : (v[31] ? 2 : 5);
      return v[31] ? 1 : 6;
   endfunction

   // encodes one instruction, predicts its outputs and updates the shadow registers
   task automatic addOp(input fpuPkg::fpOpE op, input int rd, rs1, rs2,
                        input logic [31:0] intSrc, readData);
      entryT e;
      logic [31:0] x, y, res;
      logic anyNaN, anySNaN, bothZero, lt, eq;
      logic [6:0] f7;
      logic [2:0] f3;
      x = model[rs1];
      y = model[rs2];
      anyNaN = isNaN(x) || isNaN(y);
      anySNaN = isSNaN(x) || isSNaN(y);
      bothZero = (x[30:0] == 0) && (y[30:0] == 0);
      eq = !anyNaN && ((x == y) || bothZero);
      lt = !anyNaN && !bothZero && (orderKey(x) < orderKey(y));
      res = 32'h0;
      e.op       = op;
      e.rs1      = rs1;
      e.rs2      = rs2;
      e.intSrc   = intSrc;
      e.readData = readData;
      e.expInt   = 32'h0;
      e.expStore = 32'h0;
      e.expFlags = 5'h0;
      case (op)
         fpuPkg::opSgnj:  res = {y[31], x[30:0]};
         fpuPkg::opSgnjn: res = {~y[31], x[30:0]};
         fpuPkg::opSgnjx: res = {x[31] ^ y[31], x[30:0]};
         fpuPkg::opMin, fpuPkg::opMax: begin
            if (isNaN(x) && isNaN(y)) res = 32'h7fc0_0000;
            else if (isNaN(x)) res = y;
            else if (isNaN(y)) res = x;
            else if ((orderKey(x) < orderKey(y)) == (op == fpuPkg::opMin)) res = x;
            else res = y;
            e.expFlags = {anySNaN, 4'h0};
         end
         fpuPkg::opEq: begin
            e.expInt   = 32'(eq);
            e.expFlags = {anySNaN, 4'h0};
         end
         fpuPkg::opLt: begin
            e.expInt   = 32'(lt);
            e.expFlags = {anyNaN, 4'h0};
         end
         fpuPkg::opLe: begin
            e.expInt   = 32'(lt | eq);
            e.expFlags = {anyNaN, 4'h0};
         end
         fpuPkg::opClass: e.expInt = 32'h1 << classIdx(x);
         fpuPkg::opMvX:   e.expInt = x;
         fpuPkg::opMvW:   res = intSrc;
         fpuPkg::opLoad:  res = readData;
         fpuPkg::opStore: e.expStore = y;
         default: ;
      endcase
      // funct7 and funct3 of the OP-FP encodings
      case (op)
         fpuPkg::opSgnj, fpuPkg::opSgnjn, fpuPkg::opSgnjx: f7 = 7'b0010000;
         fpuPkg::opMin, fpuPkg::opMax:                     f7 = 7'b0010100;
         fpuPkg::opEq, fpuPkg::opLt, fpuPkg::opLe:         f7 = 7'b1010000;
         fpuPkg::opClass, fpuPkg::opMvX:                   f7 = 7'b1110000;
         fpuPkg::opMvW:                                    f7 = 7'b1111000;
         default:                                          f7 = 7'h0;
      endcase
      case (op)
         fpuPkg::opSgnjn, fpuPkg::opMax, fpuPkg::opLt, fpuPkg::opClass: f3 = 3'd1;
         fpuPkg::opSgnjx, fpuPkg::opEq:                                 f3 = 3'd2;
         default:                                                       f3 = 3'd0;
      endcase
      if (op == fpuPkg::opLoad) e.instr = {12'h0, 5'd0, 3'b010, 5'(rd), 7'b0000111};
      else if (op == fpuPkg::opStore) e.instr = {7'h0, 5'(rs2), 5'd0, 3'b010, 5'd0, 7'b0100111};
      else if (op == fpuPkg::opNone) e.instr = 32'h0000_0013;   // integer addi, not ours
      else e.instr = {f7, (&f7[6:5] ? 5'd0 : 5'(rs2)), 5'(rs1), f3, 5'(rd), 7'b1010011};
      if (op inside {fpuPkg::opSgnj, fpuPkg::opSgnjn, fpuPkg::opSgnjx, fpuPkg::opMin,
                     fpuPkg::opMax, fpuPkg::opMvW, fpuPkg::opLoad}) model[rd] = res;
      tbl.push_back(e);
   endtask

   task automatic buildTable();
      fpuPkg::fpOpE fpOps[5] = '{fpuPkg::opSgnj, fpuPkg::opSgnjn, fpuPkg::opSgnjx,
                                 fpuPkg::opMin, fpuPkg::opMax};
      int pa[$];
      int pb[$];
      for (int i = 0; i < 32; i++) model[i] = 32'h0;
      // loads read back through W forward, regfile, M forward and a stall
      addOp(fpuPkg::opLoad, 1, 0, 0, 0, $urandom);
      addOp(fpuPkg::opLoad, 2, 0, 0, 0, $urandom);
      addOp(fpuPkg::opMvX, 0, 1, 0, 0, 0);
      addOp(fpuPkg::opMvX, 0, 2, 0, 0, 0);
      addOp(fpuPkg::opLoad, 3, 0, 0, 0, $urandom);
      repeat (3) addOp(fpuPkg::opNone, 0, 0, 0, 0, 0);
      addOp(fpuPkg::opMvX, 0, 3, 0, 0, 0);
      addOp(fpuPkg::opMvW, 4, 0, 0, $urandom, 0);
      addOp(fpuPkg::opMvX, 0, 4, 0, 0, 0);
      addOp(fpuPkg::opLoad, 5, 0, 0, 0, $urandom);
      addOp(fpuPkg::opMvX, 0, 5, 0, 0, 0);       // load-use on rs1
      addOp(fpuPkg::opLoad, 6, 0, 0, 0, $urandom);
      addOp(fpuPkg::opStore, 0, 0, 6, 0, 0);     // load-use on rs2
      for (int i = 0; i < 4; i++) begin
         addOp(fpuPkg::opMvW, 7, 0, 0, $urandom, 0);
         addOp(fpuPkg::opStore, 0, 0, 7, 0, 0);
      end
      // every class pattern in f8..f17, random words in f18 and f19
      for (int i = 0; i < 10; i++) begin
         addOp(fpuPkg::opLoad, 8 + i, 0, 0, 0, spec[i]);
         addOp(fpuPkg::opClass, 0, 8 + i, 0, 0, 0);
      end
      addOp(fpuPkg::opMvW, 18, 0, 0, $urandom, 0);
      addOp(fpuPkg::opMvW, 19, 0, 0, $urandom, 0);
      for (int i = 0; i < 12; i++) begin
         pa.push_back(8 + i);
         pb.push_back(8 + ((i * 5 + 3) % 12));
      end
      pa.push_back(12);                        // qNaN and sNaN together
      pb.push_back(13);
      pa.push_back(13);
      pb.push_back(12);
      pa.push_back(8);                         // +0 against -0
      pb.push_back(9);
      pa.push_back(9);
      pb.push_back(8);
      foreach (pa[i]) begin
         foreach (fpOps[k]) begin
            addOp(fpOps[k], 20, pa[i], pb[i], 0, 0);
            addOp(fpuPkg::opMvX, 0, 20, 0, 0, 0);
         end
         addOp(fpuPkg::opEq, 0, pa[i], pb[i], 0, 0);
         addOp(fpuPkg::opLt, 0, pa[i], pb[i], 0, 0);
         addOp(fpuPkg::opLe, 0, pa[i], pb[i], 0, 0);
      end
   endtask

   ////////////////////
   // drive and check
   ////////////////////
   task automatic applyInputs();
      instrD    = (dIdx >= 0) ? tbl[dIdx].instr : 32'h0000_0013;
      intSrcE   = (eIdx >= 0) ? tbl[eIdx].intSrc : 32'h0;
      readDataW = (wIdx >= 0) ? tbl[wIdx].readData : 32'h0;
   endtask

   // no table entry left in D, E or M
   function automatic logic pipeEmpty();
      return dIdx < 0 && eIdx < 0 && mIdx < 0;
   endfunction

   task automatic checkOutputs();
      logic expStall, isInt;
      fpuPkg::fpOpE opE, opM;
      int rdM;
      opM = (mIdx >= 0) ? tbl[mIdx].op : fpuPkg::opNone;
      opE = (eIdx >= 0) ? tbl[eIdx].op : fpuPkg::opNone;
      rdM = (mIdx >= 0) ? int'(tbl[mIdx].instr[11:7]) : 0;
      // load in M whose register the E instruction reads
      expStall = (opM == fpuPkg::opLoad) && (
         (opE inside {[fpuPkg::opSgnj:fpuPkg::opMvX]} && tbl[eIdx].rs1 == rdM) ||
         (opE inside {[fpuPkg::opSgnj:fpuPkg::opLe], fpuPkg::opStore} && tbl[eIdx].rs2 == rdM));
      checkBit("fStallD", fStallD, expStall);
      isInt = opM inside {fpuPkg::opEq, fpuPkg::opLt, fpuPkg::opLe, fpuPkg::opClass,
                          fpuPkg::opMvX};
      checkBit("fWriteIntM", fWriteIntM, isInt);
      checkBit("fStoreM", fStoreM, opM == fpuPkg::opStore);
      checkFlags("setFflagsM", setFflagsM, (mIdx >= 0) ? tbl[mIdx].expFlags : 5'h0);
      if (isInt) checkInt("fIntResM", fIntResM, tbl[mIdx].expInt);
      if (opM == fpuPkg::opStore) checkData("fWriteDataM", fWriteDataM, tbl[mIdx].expStore);
   endtask

   initial begin
      instrD = 32'h0000_0013;
      intSrcE = 32'h0;
      readDataW = 32'h0;
      void'($urandom(32'h1d28_2e7f));
      buildTable();
      for (t = 0; t < 20 && !arstN; t++) @(posedge clk);
      if (!arstN) stopRun("reset was never released");
      @(negedge clk);
      dIdx    = 0;
      eIdx    = -1;
      mIdx    = -1;
      wIdx    = -1;
      nextIdx = 1;
      applyInputs();
      for (cyc = 0; cyc < 3 * tbl.size() + 20 && !pipeEmpty(); cyc++) begin
         stalled = fStallD;                // value seen by the coming rising edge
         @(posedge clk);
         @(negedge clk);
         wIdx = mIdx;
         if (stalled) mIdx = -1;           // bubble, E holds
         else begin
            mIdx = eIdx;
            eIdx = dIdx;
            dIdx = (nextIdx < tbl.size()) ? nextIdx : -1;
            nextIdx++;
         end
         applyInputs();
         checkOutputs();
      end
      if (!pipeEmpty()) stopRun("pipeline did not drain in time");
      else begin
         $display("TESTBENCH PASSED");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== testbench/fpu_props.sv ====
/*
  concurrent checks on the FPU outputs, bound into fpu
  flags may only come out next to a compare or a min/max in M
*/
`default_nettype none

module fpu_props (
   input logic                      clk,
   input logic                      arstN,
   input logic                      fWriteIntM,
   input logic                      fStoreM,
   input logic                      fStallD,
   input logic [fpuPkg::flagW-1:0]  setFflagsM,
   input fpuPkg::fpOpE              opM
);
   timeunit 1ns;
   timeprecision 100ps;

   // pipe holds bubbles during reset
   idleInReset: assert property (@(posedge clk)
      !arstN |-> (!fWriteIntM && !fStoreM && !fStallD && setFflagsM == '0))
      else $error("outputs not idle during reset");

   stallOneCycle: assert property (@(posedge clk) disable iff (!arstN)
      fStallD |=> !fStallD)
      else $error("load-use stall longer than one cycle");

   oneStrobe: assert property (@(posedge clk) disable iff (!arstN)
      !(fWriteIntM && fStoreM))
      else $error("int write and store strobes together");

   // flag register and op register must stay aligned through stalls
   flagsQuiet: assert property (@(posedge clk) disable iff (!arstN)
      (setFflagsM != '0) |-> (opM inside {fpuPkg::opEq, fpuPkg::opLt, fpuPkg::opLe,
                                          fpuPkg::opMin, fpuPkg::opMax}))
      else $error("exception flags without a compare or min/max in M");

endmodule

bind fpu fpu_props u_props (.clk, .arstN, .fWriteIntM, .fStoreM, .fStallD, .setFflagsM, .opM);

`default_nettype wire

// ==== testbench/tbClock.sv ====
/*
  clock and reset for the FPU testbench
  100 ns period, reset low for 4 rising edges, released on a falling edge
*/
`default_nettype none

module tbClock (
   output logic clk,
   output logic arstN
);
   timeunit 1ns;
   timeprecision 100ps;

   initial clk = 1'b0;
   always #50 clk = ~clk;

   initial begin
      arstN = 1'b0;
      repeat (4) @(posedge clk);
      @(negedge clk);
      arstN = 1'b1;                        // away from the sampling edge
   end

endmodule

`default_nettype wire
